// ==== logic/ex_consts.svh ====
// Execute stage constants
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath and register file widths
`define EX_XLEN       32
`define EX_REG_ADDR_W 5
`define EX_ALU_OP_W   4

// ALU opcodes, arithmetic and logic group
`define EX_ALU_ADD  4'd0
`define EX_ALU_SUB  4'd1
`define EX_ALU_AND  4'd2
`define EX_ALU_OR   4'd3
`define EX_ALU_XOR  4'd4
`define EX_ALU_SLL  4'd5
`define EX_ALU_SRL  4'd6
`define EX_ALU_SRA  4'd7
// Set-less-than and branch compare group
`define EX_ALU_SLT  4'd8
`define EX_ALU_SLTU 4'd9
`define EX_ALU_EQ   4'd10
`define EX_ALU_NE   4'd11
`define EX_ALU_LT   4'd12
`define EX_ALU_GE   4'd13
`define EX_ALU_LTU  4'd14
`define EX_ALU_GEU  4'd15

// Multiplier operators
`define EX_MUL_LO  2'd0
`define EX_MUL_HSS 2'd1
`define EX_MUL_HSU 2'd2
`define EX_MUL_HUU 2'd3

`endif

// ==== logic/ex_pkg.sv ====
// Execute stage types
`include "ex_consts.svh"

package ex_pkg;

  // Operand and result word
  typedef logic [`EX_XLEN-1:0] word_t;

  // Register file index
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  // ALU opcode
  typedef logic [`EX_ALU_OP_W-1:0] alu_op_t;

  // Multiplier operator, low or high word and signedness
  typedef logic [1:0] mul_op_t;

  // Iterative multiplier states
  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_STEP,
    MULT_DONE
  } mult_state_e;

endpackage

// ==== logic/ex_mult_if.sv ====
// Multiplier request and result bus
`timescale 1ns/1ps

interface ex_mult_if
  import ex_pkg::*;
();

  // Request side, held by the stage while the instruction sits in EX
  logic    en;
  mul_op_t op;
  word_t   op_a;
  word_t   op_b;
  // Stage can take a new instruction
  logic    ex_ready;

  // Result side
  word_t   result;
  logic    ready;
  logic    multicycle;

  // Execute stage view
  modport stage (
    output en, op, op_a, op_b, ex_ready,
    input  result, ready, multicycle
  );

  // Multiplier view
  modport unit (
    input  en, op, op_a, op_b, ex_ready,
    output result, ready, multicycle
  );

endinterface

// ==== logic/ex_alu.sv ====
// Single-cycle ALU
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu
  import ex_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  alu_op_t operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    comparison_result_o,
  output logic    ready_o
);

  localparam int unsigned SHAMT_W = $clog2(`EX_XLEN);
  localparam int unsigned MSB     = `EX_XLEN - 1;

  logic               is_sub;
  word_t              adder_b;
  logic [`EX_XLEN:0]  adder_sum;
  word_t              adder_res;
  logic               carry;
  logic               is_eq;
  logic               is_lt;
  logic               is_ltu;
  logic [SHAMT_W-1:0] shamt;
  word_t              shl;
  word_t              shr_l;
  word_t              shr_a;
  logic               cmp;

  //////////////////////////////////////////////////
  // Shared adder and comparisons
  //////////////////////////////////////////////////

  // Everything except ADD subtracts, compares included
  assign is_sub    = (operator_i != `EX_ALU_ADD);
  assign adder_b   = is_sub ? ~operand_b_i : operand_b_i;
  // Carry-in of one completes the two's complement of B
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{`EX_XLEN{1'b0}}, is_sub};
  assign adder_res = adder_sum[`EX_XLEN-1:0];
  // Carry out of A - B set means A >= B unsigned
  assign carry     = adder_sum[`EX_XLEN];

  assign is_eq  = (adder_res == '0);
  assign is_ltu = ~carry;
  // Opposite signs decide directly, else the difference sign does
  assign is_lt  = (operand_a_i[MSB] ^ operand_b_i[MSB]) ? operand_a_i[MSB] : adder_res[MSB];

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Only the low bits of B count as shift amount
  assign shamt = operand_b_i[SHAMT_W-1:0];
  assign shl   = operand_a_i << shamt;
  assign shr_l = operand_a_i >> shamt;
  assign shr_a = word_t'($signed(operand_a_i) >>> shamt);

  // Branch condition, also the set-less-than bit
  always_comb
  begin
    case (operator_i)
      `EX_ALU_SLT:  cmp = is_lt;
      `EX_ALU_SLTU: cmp = is_ltu;
      `EX_ALU_EQ:   cmp = is_eq;
      `EX_ALU_NE:   cmp = ~is_eq;
      `EX_ALU_LT:   cmp = is_lt;
      `EX_ALU_GE:   cmp = ~is_lt;
      `EX_ALU_LTU:  cmp = is_ltu;
      `EX_ALU_GEU:  cmp = ~is_ltu;
      default:      cmp = 1'b0;
    endcase
  end

  // Result select
  always_comb
  begin
    case (operator_i)
      `EX_ALU_ADD,
      `EX_ALU_SUB: result_o = adder_res;
      `EX_ALU_AND: result_o = operand_a_i & operand_b_i;
      `EX_ALU_OR:  result_o = operand_a_i | operand_b_i;
      `EX_ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      `EX_ALU_SLL: result_o = shl;
      `EX_ALU_SRL: result_o = shr_l;
      `EX_ALU_SRA: result_o = shr_a;
      // Compare group writes the condition bit zero-extended
      default:     result_o = {{(`EX_XLEN-1){1'b0}}, cmp};
    endcase
  end

  assign comparison_result_o = cmp;

  // No divider, so always a single cycle
  assign ready_o = 1'b1;

  // Decode must never hand over an undriven opcode
  a_opcode_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(operator_i)
  ) else $error("ALU opcode is unknown");

endmodule

// ==== logic/ex_mult.sv ====
// Iterative 32x32 multiplier
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_mult
  import ex_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  ex_mult_if.unit mult
);

  localparam int unsigned NUM_BYTES = `EX_XLEN / 8;
  localparam int unsigned CNT_W     = $clog2(NUM_BYTES);
  localparam int unsigned DW        = 2 * `EX_XLEN;
  localparam int unsigned MSB       = `EX_XLEN - 1;

  mult_state_e      state_q;
  mult_state_e      state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             last_step;
  logic             accept;
  logic             a_neg;
  logic             b_neg;
  word_t            a_mag_q;
  word_t            b_mag_q;
  logic             neg_q;
  logic [7:0]       b_byte;
  logic [DW-1:0]    partial;
  logic [DW-1:0]    acc_q;
  logic [DW-1:0]    product;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  assign accept    = (state_q == MULT_IDLE) && mult.en;
  assign last_step = (cnt_q == CNT_W'(NUM_BYTES - 1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (mult.en) state_d = MULT_STEP;
      // One byte of B per cycle
      MULT_STEP: if (last_step) state_d = MULT_DONE;
      // Hold the result until the stage moves on
      MULT_DONE: if (mult.ex_ready) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
        cnt_q <= '0;
      else if (state_q == MULT_STEP)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // A is signed for HSS and HSU, B only for HSS
  assign a_neg = mult.op_a[MSB] && (mult.op == `EX_MUL_HSS || mult.op == `EX_MUL_HSU);
  assign b_neg = mult.op_b[MSB] && (mult.op == `EX_MUL_HSS);

  // A times the current byte of B, moved to its weight
  assign b_byte  = b_mag_q[8*cnt_q +: 8];
  assign partial = ({{`EX_XLEN{1'b0}}, a_mag_q} * {{(DW-8){1'b0}}, b_byte}) << (8 * cnt_q);

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      // Magnitudes fit 32 bits, even for the most negative value
      a_mag_q <= a_neg ? -mult.op_a : mult.op_a;
      b_mag_q <= b_neg ? -mult.op_b : mult.op_b;
      neg_q   <= a_neg ^ b_neg;
      acc_q   <= '0;
    end
    else if (state_q == MULT_STEP)
    begin
      acc_q <= acc_q + partial;
    end
  end

  // Sign restored on the full 64-bit product
  assign product = neg_q ? -acc_q : acc_q;

  assign mult.result = (mult.op == `EX_MUL_LO) ? product[`EX_XLEN-1:0] : product[DW-1:`EX_XLEN];

  // Idle and free, or finished
  assign mult.ready      = ((state_q == MULT_IDLE) && !mult.en) || (state_q == MULT_DONE);
  assign mult.multicycle = (state_q != MULT_IDLE);

  // ID holds the operator for the whole multiply
  a_op_stable: assert property (
    @(posedge clk) disable iff (!rst_n) (state_q == MULT_STEP) |-> $stable(mult.op)
  ) else $error("Multiplier operator changed during STEP");

endmodule

// ==== logic/ex_stage.sv ====
// Execute stage
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // ALU request from ID
  input  alu_op_t   alu_operator_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,

  // Multiplier request from ID
  input  logic      mult_en_i,
  input  mul_op_t   mult_operator_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  output logic      mult_multicycle_o,

  // CSR read data
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Destination and write enables from ID
  input  logic      branch_in_ex_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_alu_we_i,
  input  logic      regfile_we_i,

  // EX/WB pipeline outputs
  output reg_addr_t regfile_waddr_wb_o,
  output logic      regfile_we_wb_o,

  // Forwarding to ID and register file
  output reg_addr_t regfile_alu_waddr_fw_o,
  output logic      regfile_alu_we_fw_o,
  output word_t     regfile_alu_wdata_fw_o,

  // Branch resolution to IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  // Stall control
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  word_t alu_csr_result;
  logic  alu_cmp_result;
  logic  alu_ready;
  logic  mult_ready;
  logic  units_ready;
  // WB and EX both want the single ALU write port
  logic  we_conflict;

  ex_mult_if mult_bus ();

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////

  ex_alu i_alu (
    .clk                 (clk),
    .rst_n               (rst_n),
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result),
    .ready_o             (alu_ready)
  );

  // Request levels straight from ID
  assign mult_bus.en       = mult_en_i;
  assign mult_bus.op       = mult_operator_i;
  assign mult_bus.op_a     = mult_operand_a_i;
  assign mult_bus.op_b     = mult_operand_b_i;
  assign mult_bus.ex_ready = ex_ready_o;

  ex_mult i_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .mult  (mult_bus.unit)
  );

  assign mult_ready        = mult_bus.ready;
  assign mult_multicycle_o = mult_bus.multicycle;

  // Result mux, multiplier over CSR over ALU
  assign alu_csr_result         = csr_access_i ? csr_rdata_i : alu_result;
  assign regfile_alu_wdata_fw_o = mult_en_i ? mult_bus.result : alu_csr_result;

  // Forwarding address and enable
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Branch target comes in on operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////
  // Stall logic
  //////////////////////////////////////////////////

  assign we_conflict = regfile_we_wb_o && regfile_alu_we_i;
  assign units_ready = alu_ready && mult_ready && lsu_ready_ex_i && wb_ready_i;

  // A branch finishes in EX and never needs WB
  assign ex_ready_o = (units_ready && !we_conflict) || branch_in_ex_i;
  // Valid only looks forward, never at ex_ready_o
  assign ex_valid_o = units_ready;

  //////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      regfile_we_wb_o <= regfile_we_i;
      // Address kept when nothing is written
      if (regfile_we_i)
        regfile_waddr_wb_o <= regfile_alu_waddr_i;
    end
    else if (wb_ready_i)
    begin
      // WB drained and nothing new, so flush the bubble
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Never hand WB an instruction it cannot take
  a_valid_needs_wb: assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_o |-> wb_ready_i
  ) else $error("EX valid while WB is not ready");

  // Port conflict must stall, except for a branch
  a_conflict_stalls: assert property (
    @(posedge clk) disable iff (!rst_n) (we_conflict && !branch_in_ex_i) |-> !ex_ready_o
  ) else $error("Write port conflict without stall");

endmodule

// ==== verif/tb_ex_stage.sv ====
// Execute stage testbench
`timescale 1ns/1ps
`include "ex_consts.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  logic      clk;
  logic      rst_n;
  alu_op_t   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      mult_en_i;
  mul_op_t   mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  logic      mult_multicycle_o;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      branch_in_ex_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_alu_we_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_wb_o;
  logic      regfile_we_wb_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  logic      regfile_alu_we_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      lsu_ready_ex_i;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Run bookkeeping
  int errors;
  int checks;
  int tests_run;
  int errors_mark;

  ex_stage i_dut (.*);

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////

  // Branch and set-less-than condition
  function automatic logic cond_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      `EX_ALU_SLT,
      `EX_ALU_LT:   return $signed(a) < $signed(b);
      `EX_ALU_SLTU,
      `EX_ALU_LTU:  return a < b;
      `EX_ALU_EQ:   return a == b;
      `EX_ALU_NE:   return a != b;
      `EX_ALU_GE:   return $signed(a) >= $signed(b);
      `EX_ALU_GEU:  return a >= b;
      default:      return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      `EX_ALU_ADD: return a + b;
      `EX_ALU_SUB: return a - b;
      `EX_ALU_AND: return a & b;
      `EX_ALU_OR:  return a | b;
      `EX_ALU_XOR: return a ^ b;
      `EX_ALU_SLL: return a << b[4:0];
      `EX_ALU_SRL: return a >> b[4:0];
      `EX_ALU_SRA: return $signed(a) >>> b[4:0];
      default:     return word_t'(cond_model(op, a, b));
    endcase
  endfunction

  // Full 64-bit product of the extended operands
  function automatic word_t mult_model(input mul_op_t op, input word_t a, input word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    ax = {32'b0, a};
    bx = {32'b0, b};
    if (op == `EX_MUL_HSS || op == `EX_MUL_HSU)
      ax = {{32{a[31]}}, a};
    if (op == `EX_MUL_HSS)
      bx = {{32{b[31]}}, b};
    prod = ax * bx;
    return (op == `EX_MUL_LO) ? prod[31:0] : prod[63:32];
  endfunction

  //////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////

  task automatic compare(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, errors - errors_mark);
    errors_mark = errors;
    tests_run++;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  // Two rising edges in reset, outputs checked in between
  task automatic reset_values();
    rst_n = 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h0);
    compare("regfile_waddr_wb_o", word_t'(regfile_waddr_wb_o), 32'h0);
    compare("mult_multicycle_o", word_t'(mult_multicycle_o), 32'h0);
    compare("mult state", word_t'(i_dut.i_mult.state_q), word_t'(MULT_IDLE));
    @(posedge clk);
    rst_n <= 1'b1;
    report_test("reset_values");
  endtask

  task automatic alu_vector(input alu_op_t op, input word_t a, input word_t b);
    word_t c;
    c = $urandom;
    @(posedge clk);
    alu_operator_i  <= op;
    alu_operand_a_i <= a;
    alu_operand_b_i <= b;
    alu_operand_c_i <= c;
    @(negedge clk);
    compare("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, alu_model(op, a, b));
    if (op >= `EX_ALU_SLT)
      compare("branch_decision_o", word_t'(branch_decision_o), word_t'(cond_model(op, a, b)));
    compare("jump_target_o", jump_target_o, c);
  endtask

  task automatic alu_sweep();
    word_t edge_a [6] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff,
                          32'h80000001, 32'hc3a5f00f};
    word_t edge_b [6] = '{32'h0, 32'hffffffff, 32'h1, 32'h80000000,
                          32'h0, 32'h1f};
    for (int op = 0; op < 16; op++)
    begin
      for (int i = 0; i < 6; i++)
        alu_vector(alu_op_t'(op), edge_a[i], edge_b[i]);
      for (int i = 0; i < 20; i++)
        alu_vector(alu_op_t'(op), $urandom, $urandom);
    end
    report_test("alu_sweep");
  endtask

  task automatic csr_forwarding();
    word_t     rdata;
    reg_addr_t addr;
    logic      we;
    for (int i = 0; i < 10; i++)
    begin
      rdata = $urandom;
      addr  = reg_addr_t'($urandom);
      we    = $urandom % 2;
      @(posedge clk);
      csr_access_i        <= 1'b1;
      csr_rdata_i         <= rdata;
      alu_operator_i      <= alu_op_t'($urandom);
      regfile_alu_waddr_i <= addr;
      regfile_alu_we_i    <= we;
      @(negedge clk);
      compare("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, rdata);
      compare("regfile_alu_we_fw_o", word_t'(regfile_alu_we_fw_o), word_t'(we));
      compare("regfile_alu_waddr_fw_o", word_t'(regfile_alu_waddr_fw_o), word_t'(addr));
    end
    @(posedge clk);
    csr_access_i     <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    report_test("csr_forwarding");
  endtask

  // Valid expected on the fifth edge after en is seen
  task automatic multiply_once(input mul_op_t op, input word_t a, input word_t b);
    int edges;
    edges = 0;
    @(posedge clk);
    mult_en_i        <= 1'b1;
    mult_operator_i  <= op;
    mult_operand_a_i <= a;
    mult_operand_b_i <= b;
    @(negedge clk);
    compare("mult_multicycle_o", word_t'(mult_multicycle_o), 32'h0);
    while (!ex_valid_o && edges < 20)
    begin
      compare("ex_ready_o", word_t'(ex_ready_o), 32'h0);
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (edges == 1)
        compare("mult_multicycle_o", word_t'(mult_multicycle_o), 32'h1);
    end
    if (!ex_valid_o)
    begin
      errors++;
      $display("Timeout: multiplier result never became valid (op %0d)", op);
    end
    else
    begin
      compare("edges to ex_valid_o", edges, 32'd5);
      compare("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, mult_model(op, a, b));
    end
    @(posedge clk);
    mult_en_i <= 1'b0;
  endtask

  task automatic mult_operators();
    word_t edge_a [4] = '{32'h80000000, 32'h80000000, 32'hffffffff, 32'h7fffffff};
    word_t edge_b [4] = '{32'h80000000, 32'hffffffff, 32'hffffffff, 32'h80000000};
    for (int op = 0; op < 4; op++)
    begin
      for (int i = 0; i < 4; i++)
        multiply_once(mul_op_t'(op), edge_a[i], edge_b[i]);
      for (int i = 0; i < 4; i++)
        multiply_once(mul_op_t'(op), $urandom, $urandom);
    end
    report_test("mult_operators");
  endtask

  task automatic wb_backpressure();
    word_t a;
    word_t b;
    word_t exp;
    a   = $urandom;
    b   = $urandom;
    exp = mult_model(`EX_MUL_HSS, a, b);
    @(posedge clk);
    mult_en_i           <= 1'b1;
    mult_operator_i     <= `EX_MUL_HSS;
    mult_operand_a_i    <= a;
    mult_operand_b_i    <= b;
    wb_ready_i          <= 1'b0;
    regfile_we_i        <= 1'b1;
    regfile_alu_waddr_i <= 5'd9;
    // Accept plus four STEP edges
    repeat (5) @(posedge clk);
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clk);
      compare("ex_valid_o", word_t'(ex_valid_o), 32'h0);
      compare("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
      @(posedge clk);
    end
    wb_ready_i <= 1'b1;
    @(negedge clk);
    compare("ex_valid_o", word_t'(ex_valid_o), 32'h1);
    compare("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
    // Completion edge, then LSU stall keeps EX empty
    @(posedge clk);
    mult_en_i      <= 1'b0;
    lsu_ready_ex_i <= 1'b0;
    regfile_we_i   <= 1'b0;
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h1);
    compare("regfile_waddr_wb_o", word_t'(regfile_waddr_wb_o), 32'd9);
    compare("ex_valid_o", word_t'(ex_valid_o), 32'h0);
    @(posedge clk);
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h0);
    @(posedge clk);
    lsu_ready_ex_i <= 1'b1;
    report_test("wb_backpressure");
  endtask

  task automatic pipe_register_conflict();
    @(posedge clk);
    regfile_we_i        <= 1'b1;
    regfile_alu_waddr_i <= 5'd17;
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h0);
    @(posedge clk);
    regfile_we_i        <= 1'b0;
    regfile_alu_waddr_i <= 5'd3;
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h1);
    compare("regfile_waddr_wb_o", word_t'(regfile_waddr_wb_o), 32'd17);
    // No write, so the address stays
    @(posedge clk);
    regfile_we_i <= 1'b1;
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h0);
    compare("regfile_waddr_wb_o", word_t'(regfile_waddr_wb_o), 32'd17);
    // Both stalled, register holds
    @(posedge clk);
    wb_ready_i   <= 1'b0;
    regfile_we_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare("regfile_we_wb_o", word_t'(regfile_we_wb_o), 32'h1);
    compare("regfile_waddr_wb_o", word_t'(regfile_waddr_wb_o), 32'd3);
    // WB write pending plus an ALU write
    @(posedge clk);
    wb_ready_i       <= 1'b1;
    regfile_we_i     <= 1'b1;
    regfile_alu_we_i <= 1'b1;
    @(negedge clk);
    compare("ex_ready_o", word_t'(ex_ready_o), 32'h0);
    compare("ex_valid_o", word_t'(ex_valid_o), 32'h1);
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    @(negedge clk);
    compare("ex_ready_o", word_t'(ex_ready_o), 32'h1);
    compare("ex_valid_o", word_t'(ex_valid_o), 32'h1);
    @(posedge clk);
    branch_in_ex_i   <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    regfile_we_i     <= 1'b0;
    report_test("pipe_register_conflict");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h6104));
    errors              = 0;
    checks              = 0;
    tests_run           = 0;
    errors_mark         = 0;
    clk                 = 1'b0;
    rst_n               = 1'b0;
    alu_operator_i      = `EX_ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = `EX_MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;

    reset_values();
    alu_sweep();
    csr_forwarding();
    mult_operators();
    wb_backpressure();
    pipe_register_conflict();

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== ex_stage.f ====
+incdir+logic
logic/ex_pkg.sv
logic/ex_mult_if.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_stage.sv
verif/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f ex_stage.f --top-module tb_ex_stage \
  --Mdir "$BUILD_DIR" -o tb_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_ex_stage" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG_FILE"; then
  exit 1
fi
exit 0
